// File: Makefile
TOP := tb_tqv_periph_fabric
LOG := sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --assert --timing --timescale 1ns/1ps -Wno-fatal \
		--top-module $(TOP) -f flist.f

run: build
	./obj_dir/V$(TOP) +verilator+error+limit+100 | tee $(LOG)
	grep -qx "STATUS: PASS" $(LOG)

lint:
	verilator --lint-only -Wall --timing --timescale 1ns/1ps --top-module $(TOP) -f flist.f

clean:
	rm -rf obj_dir $(LOG)

// File: flist.f
src/tqv_periph_pkg.sv
src/periph_addr_decode.sv
src/periph_read_buffer.sv
src/gpio_regs.sv
src/pin_out_mux.sv
src/tqv_periph_fabric.sv
sim/tb_clock_gen.sv
sim/tqv_periph_fabric_sva.sv
sim/tb_tqv_periph_fabric.sv

// File: sim/tb_clock_gen.sv
// Testbench clock and reset source
// 8 ns clock, reset held low for the first 4 rising edges
module tb_clock_gen (
    output logic clk,
    output logic rst_n
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;    // Released away from the sampling edge
    end

endmodule

// File: sim/tb_tqv_periph_fabric.sv
// Testbench for the peripheral bus fabric
// Models the external slots and walks the core through GPIO, user and simple slot accesses
module tb_tqv_periph_fabric;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int MAX_CYCLES = 400;    // About five times the stimulus length

    logic                         clk;
    logic                         rst_n;
    tqv_periph_pkg::addr_t        i_addr;
    tqv_periph_pkg::word_t        i_data;
    tqv_periph_pkg::acc_t         i_data_write_n;
    tqv_periph_pkg::acc_t         i_data_read_n;
    logic                         i_read_complete;
    tqv_periph_pkg::pins_t        i_ui_in;
    tqv_periph_pkg::word_t        o_data;
    logic                         o_data_ready;
    tqv_periph_pkg::pins_t        o_uo_out;
    logic [5:0]                   o_slot_addr;
    tqv_periph_pkg::word_t        o_slot_data;
    tqv_periph_pkg::acc_t  [7:2]  o_user_write_n;
    tqv_periph_pkg::acc_t  [7:2]  o_user_read_n;
    tqv_periph_pkg::word_t [7:2]  i_user_data;
    logic                  [7:2]  i_user_ready;
    tqv_periph_pkg::pins_t [7:2]  i_user_uo;
    logic                  [3:0]  o_simple_write;
    tqv_periph_pkg::byte_t [3:0]  i_simple_data;
    tqv_periph_pkg::pins_t [3:0]  i_simple_uo;
    integer                       seed = 32'h07f05ab3;
    int                           slow_cnt = 0;

    tb_clock_gen clk_gen_i (.clk(clk), .rst_n(rst_n));

    tqv_periph_fabric dut_i (.*);

    // Slot words carry the slot number and offset, so a wrong route shows up
    function automatic tqv_periph_pkg::word_t slot_word(int k, logic [5:0] ofs);
        return 32'hC0DE_0000 | (32'(k) << 8) | 32'(ofs);
    endfunction

    always_comb begin
        for (int k = 2; k < 8; k++) begin
            i_user_data[k]  = slot_word(k, o_slot_addr);
            i_user_ready[k] = (k != 3) || (slow_cnt == 1);    // Slot 3 answers on cycle two
        end
    end

    always @(posedge clk) begin
        slow_cnt <= (o_user_read_n[3] != 2'b11) ? slow_cnt + 1 : 0;
    end

    task automatic write_reg(input tqv_periph_pkg::addr_t addr, input tqv_periph_pkg::word_t data,
                             input tqv_periph_pkg::acc_t code);
        @(negedge clk);
        i_addr         = addr;
        i_data         = data;
        i_data_write_n = code;
        @(negedge clk);
        i_data_write_n = 2'b11;
    endtask

    task automatic read_reg(input tqv_periph_pkg::addr_t addr);
        @(negedge clk);
        i_addr        = addr;
        i_data_read_n = 2'b10;
        @(negedge clk);
        while (!o_data_ready) begin
            @(negedge clk);
        end
        i_addr        = addr ^ 11'h004;     // Data must hold across an address change
        @(negedge clk);                     // Read held while the result is buffered
        i_data_read_n = 2'b11;
        i_addr        = '0;
        @(negedge clk);
        i_read_complete = 1'b1;
        @(negedge clk);
        i_read_complete = 1'b0;
    endtask

    always @(negedge clk) begin
        if (dut_i.sva_i.err_count != 0) begin
            $display("STATUS: FAIL");
            $fatal(1, "Stopped at the first assertion failure");
        end
    end

    initial begin
        #(MAX_CYCLES * 8);
        $display("STATUS: FAIL");
        $fatal(1, "Watchdog expired after %0d cycles", MAX_CYCLES);
    end

    initial begin
        i_addr          = '0;
        i_data          = '0;
        i_data_write_n  = 2'b11;
        i_data_read_n   = 2'b11;
        i_read_complete = 1'b0;
        i_ui_in         = 8'($random(seed));
        for (int k = 2; k < 8; k++) begin
            i_user_uo[k] = 8'($random(seed));
        end
        for (int j = 0; j < 4; j++) begin
            i_simple_uo[j]   = 8'($random(seed));
            i_simple_data[j] = 8'h5A + 8'(j);
        end
        @(posedge rst_n);
        repeat (3) @(negedge clk);          // Idle, default pin map on the outputs
        write_reg(11'h040, 32'hFFFF_FF5C, 2'b10);
        read_reg(11'h040);
        read_reg(11'h044);
        read_reg(11'h088);                  // UART slot
        read_reg(11'h0CC);                  // Slow slot 3
        read_reg(11'h1FC);
        write_reg(11'h150, 32'h0000_1234, 2'b01);
        write_reg(11'h421, 32'h0000_0077, 2'b00);
        read_reg(11'h43F);
        // Pin 2 to simple slot 3, pin 3 to user slot 5, pins 4 and 5 to missing slots
        write_reg(11'h068, 32'h13, 2'b10);
        read_reg(11'h068);
        write_reg(11'h06C, 32'h05, 2'b10);
        write_reg(11'h070, 32'h0B, 2'b10);
        write_reg(11'h074, 32'h1C, 2'b10);
        write_reg(11'h060, 32'h12, 2'b10);
        repeat (3) @(negedge clk);
        if (dut_i.sva_i.err_count != 0) begin
            $display("STATUS: FAIL");
            $fatal(1, "Assertion failures were reported");
        end else begin
            $display("STATUS: PASS");
            $finish;
        end
    end

endmodule

// File: sim/tqv_periph_fabric_sva.sv
// Bus fabric checks bound to the top level
// Shadow GPIO state and read buffer state feed the concurrent assertions
module tqv_periph_fabric_sva (
    input logic                                                  clk,
    input logic                                                  rst_n,
    input tqv_periph_pkg::addr_t                                 i_addr,
    input tqv_periph_pkg::word_t                                 i_data,
    input tqv_periph_pkg::acc_t                                  i_data_write_n,
    input tqv_periph_pkg::acc_t                                  i_data_read_n,
    input logic                                                  i_read_complete,
    input tqv_periph_pkg::pins_t                                 i_ui_in,
    input tqv_periph_pkg::word_t                                 o_data,
    input logic                                                  o_data_ready,
    input tqv_periph_pkg::pins_t                                 o_uo_out,
    input logic [5:0]                                            o_slot_addr,
    input tqv_periph_pkg::word_t                                 o_slot_data,
    input tqv_periph_pkg::acc_t  [tqv_periph_pkg::NUM_USER-1:2]   o_user_write_n,
    input tqv_periph_pkg::acc_t  [tqv_periph_pkg::NUM_USER-1:2]   o_user_read_n,
    input tqv_periph_pkg::word_t [tqv_periph_pkg::NUM_USER-1:2]   i_user_data,
    input logic                  [tqv_periph_pkg::NUM_USER-1:2]   i_user_ready,
    input tqv_periph_pkg::pins_t [tqv_periph_pkg::NUM_USER-1:2]   i_user_uo,
    input logic                  [tqv_periph_pkg::NUM_SIMPLE-1:0] o_simple_write,
    input tqv_periph_pkg::byte_t [tqv_periph_pkg::NUM_SIMPLE-1:0] i_simple_data,
    input tqv_periph_pkg::pins_t [tqv_periph_pkg::NUM_SIMPLE-1:0] i_simple_uo
);
    timeunit 1ns;
    timeprecision 1ps;

    int unsigned err_count = 0;

    logic                                                    simple_acc;
    logic [2:0]                                              uidx;
    logic [1:0]                                              sidx;
    logic                                                    wr_req;
    logic                                                    rd_req;
    logic                                                    sel_hit;
    logic                                                    sel_ready;
    logic                                                    rdy_q;
    logic                                                    hold_q;
    tqv_periph_pkg::word_t                                   sel_data;
    tqv_periph_pkg::word_t                                   exp_data;
    tqv_periph_pkg::pins_t                                   gpio_q;
    tqv_periph_pkg::pins_t                                   exp_pins;
    tqv_periph_pkg::pin_sel_t [tqv_periph_pkg::NUM_PINS-1:0] sel_q;
    tqv_periph_pkg::acc_t     [tqv_periph_pkg::NUM_USER-1:2] exp_wn;
    tqv_periph_pkg::acc_t     [tqv_periph_pkg::NUM_USER-1:2] exp_rn;
    logic [tqv_periph_pkg::NUM_SIMPLE-1:0]                   exp_sw;

    assign simple_acc = (i_addr[10:9] == 2'b10);
    assign uidx       = i_addr[8:6];
    assign sidx       = i_addr[5:4];
    assign wr_req     = (i_data_write_n != tqv_periph_pkg::ACC_NONE);
    assign rd_req     = (i_data_read_n != tqv_periph_pkg::ACC_NONE);
    assign sel_hit    = i_addr[5] && (i_addr[1:0] == 2'b00);    // Select registers 0x20..0x3C

    // Expected slot codes, strobes and selected read data
    always_comb begin
        sel_data  = '0;
        sel_ready = 1'b1;
        exp_wn    = '1;
        exp_rn    = '1;
        exp_sw    = '0;
        if (simple_acc) begin
            sel_data     = {24'h0, i_simple_data[sidx]};
            exp_sw[sidx] = wr_req;
        end else if (uidx == 3'd0) begin
            sel_ready = 1'b0;                   // Reserved slot never answers
        end else if (uidx == 3'd1) begin
            if (i_addr[5:0] == tqv_periph_pkg::GPIO_OUT_OFS) sel_data = {24'h0, gpio_q};
            else if (i_addr[5:0] == tqv_periph_pkg::GPIO_IN_OFS) sel_data = {24'h0, i_ui_in};
            else if (sel_hit) sel_data = {26'h0, sel_q[i_addr[4:2]]};
        end else begin
            sel_data     = i_user_data[uidx];
            sel_ready    = i_user_ready[uidx];
            exp_wn[uidx] = i_data_write_n;
            exp_rn[uidx] = rdy_q ? tqv_periph_pkg::ACC_NONE : i_data_read_n;
        end
    end

    // Pin i follows bit i of the slot its select names
    always_comb begin
        for (int i = 0; i < tqv_periph_pkg::NUM_PINS; i++) begin
            exp_pins[i] = 1'b0;
            if (sel_q[i][4]) begin
                if (sel_q[i][3:2] == 2'b00) exp_pins[i] = i_simple_uo[sel_q[i][1:0]][i];
            end else if (sel_q[i][3:0] == 4'd1) begin
                exp_pins[i] = gpio_q[i];
            end else if (sel_q[i][3:0] >= 4'd2 && sel_q[i][3:0] <= 4'd7) begin
                exp_pins[i] = i_user_uo[sel_q[i][2:0]][i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            gpio_q <= '0;
            rdy_q  <= 1'b0;
            hold_q <= 1'b0;
            for (int i = 0; i < tqv_periph_pkg::NUM_PINS; i++) begin
                sel_q[i] <= (i < 2) ? 6'(tqv_periph_pkg::SLOT_UART)
                                    : 6'(tqv_periph_pkg::SLOT_GPIO);
            end
        end else begin
            if (wr_req && !simple_acc && uidx == 3'd1) begin
                if (i_addr[5:0] == tqv_periph_pkg::GPIO_OUT_OFS) gpio_q <= i_data[7:0];
                if (sel_hit) sel_q[i_addr[4:2]] <= i_data[5:0];
            end
            rdy_q <= rd_req && sel_ready;
            if (rd_req && sel_ready && !hold_q) begin
                hold_q   <= 1'b1;
                exp_data <= sel_data;
            end else if (i_read_complete) begin
                hold_q <= 1'b0;
            end
        end
    end

    ready_chk: assert property (@(posedge clk) disable iff (!rst_n)
        o_data_ready == (rdy_q || wr_req))
        else begin
            err_count++;
            $error("FAILED %0t: o_data_ready is %b", $time, o_data_ready);
        end

    codes_chk: assert property (@(posedge clk) disable iff (!rst_n)
        o_user_write_n == exp_wn && o_user_read_n == exp_rn && o_simple_write == exp_sw)
        else begin
            err_count++;
            $error("FAILED %0t: slot codes or strobes wrong for address %h", $time, i_addr);
        end

    // Offset and write data reach every external slot unchanged
    bcast_chk: assert property (@(posedge clk) disable iff (!rst_n)
        o_slot_addr == i_addr[5:0] && o_slot_data == i_data)
        else begin
            err_count++;
            $error("FAILED %0t: slot bus %h/%h, expected %h/%h", $time, o_slot_addr,
                   o_slot_data, i_addr[5:0], i_data);
        end

    data_chk: assert property (@(posedge clk) disable iff (!rst_n)
        hold_q |-> o_data == exp_data)
        else begin
            err_count++;
            $error("FAILED %0t: o_data %h, expected %h", $time, o_data, exp_data);
        end

    pins_chk: assert property (@(posedge clk) disable iff (!rst_n)
        o_uo_out == exp_pins)
        else begin
            err_count++;
            $error("FAILED %0t: o_uo_out %h, expected %h", $time, o_uo_out, exp_pins);
        end

endmodule

bind tqv_periph_fabric tqv_periph_fabric_sva sva_i (.*);

// File: src/gpio_regs.sv
// GPIO register block for user slot 1
// Output register, input pin readback and one function select per output pin
module gpio_regs (
    input  logic                                                   clk,
    input  logic                                                   rst_n,
    input  logic [5:0]                                             i_slot_addr,
    input  tqv_periph_pkg::word_t                                  i_data,
    input  tqv_periph_pkg::acc_t                                   i_write_n,
    input  tqv_periph_pkg::pins_t                                  i_ui_in,
    output tqv_periph_pkg::word_t                                  o_rdata,
    output tqv_periph_pkg::pins_t                                  o_gpio_out,
    output tqv_periph_pkg::pin_sel_t [tqv_periph_pkg::NUM_PINS-1:0] o_pin_sel
);

    tqv_periph_pkg::pins_t                                  gpio_out;
    tqv_periph_pkg::pin_sel_t [tqv_periph_pkg::NUM_PINS-1:0] pin_sel;
    logic                                                   wr_en;
    logic                                                   out_hit;
    logic                                                   in_hit;
    logic                                                   sel_hit;
    logic [2:0]                                             sel_idx;

    assign wr_en   = (i_write_n != tqv_periph_pkg::ACC_NONE);
    assign out_hit = (i_slot_addr == tqv_periph_pkg::GPIO_OUT_OFS);
    assign in_hit  = (i_slot_addr == tqv_periph_pkg::GPIO_IN_OFS);

    // Select registers fill the upper half of the window, word aligned
    assign sel_hit = (i_slot_addr[5] == tqv_periph_pkg::GPIO_SEL_BASE[5])
                     && (i_slot_addr[1:0] == 2'b00);
    assign sel_idx = i_slot_addr[4:2];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            gpio_out <= '0;
        end else if (wr_en && out_hit) begin
            gpio_out <= i_data[tqv_periph_pkg::NUM_PINS-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < tqv_periph_pkg::NUM_PINS; i++) begin
                // UART owns the two lowest pins by default
                pin_sel[i] <= (i < 2) ? tqv_periph_pkg::pin_sel_t'(tqv_periph_pkg::SLOT_UART)
                                      : tqv_periph_pkg::pin_sel_t'(tqv_periph_pkg::SLOT_GPIO);
            end
        end else if (wr_en && sel_hit) begin
            pin_sel[sel_idx] <= i_data[5:0];
        end
    end

    // Readback, zero-extended
    always_comb begin
        o_rdata = '0;
        if (out_hit) begin
            o_rdata = {24'h0, gpio_out};
        end else if (in_hit) begin
            o_rdata = {24'h0, i_ui_in};
        end else if (sel_hit) begin
            o_rdata = {26'h0, pin_sel[sel_idx]};
        end
    end

    assign o_gpio_out = gpio_out;
    assign o_pin_sel  = pin_sel;

endmodule

// File: src/periph_addr_decode.sv
// Peripheral address decoder
// Picks one user or simple slot, gates its access codes and muxes back its data
module periph_addr_decode (
    input  tqv_periph_pkg::addr_t                                  i_addr,
    input  tqv_periph_pkg::acc_t                                   i_data_write_n,
    input  tqv_periph_pkg::acc_t                                   i_data_read_n,
    input  logic                                                   i_read_blocked,
    input  tqv_periph_pkg::word_t [tqv_periph_pkg::NUM_USER-1:0]   i_user_data,
    input  logic                  [tqv_periph_pkg::NUM_USER-1:0]   i_user_ready,
    input  tqv_periph_pkg::byte_t [tqv_periph_pkg::NUM_SIMPLE-1:0] i_simple_data,
    output tqv_periph_pkg::acc_t  [tqv_periph_pkg::NUM_USER-1:0]   o_user_write_n,
    output tqv_periph_pkg::acc_t  [tqv_periph_pkg::NUM_USER-1:0]   o_user_read_n,
    output logic                  [tqv_periph_pkg::NUM_SIMPLE-1:0] o_simple_write,
    output tqv_periph_pkg::word_t                                  o_sel_data,
    output logic                                                   o_sel_ready
);

    logic                                     is_simple;
    logic [tqv_periph_pkg::USER_IDX_W-1:0]    user_idx;
    logic [tqv_periph_pkg::SIMPLE_IDX_W-1:0]  simple_idx;
    logic [tqv_periph_pkg::NUM_USER-1:0]      user_sel;
    logic [tqv_periph_pkg::NUM_SIMPLE-1:0]    simple_sel;
    tqv_periph_pkg::acc_t                     read_n_masked;
    logic                                     write_req;

    assign is_simple  = (i_addr[10:9] == 2'b10);
    assign user_idx   = i_addr[6 +: tqv_periph_pkg::USER_IDX_W];
    assign simple_idx = i_addr[4 +: tqv_periph_pkg::SIMPLE_IDX_W];
    assign write_req  = (i_data_write_n != tqv_periph_pkg::ACC_NONE);

    // No fresh read reaches a slot while a result sits in the buffer
    assign read_n_masked = i_data_read_n | {2{i_read_blocked}};

    // One-hot slot select
    always_comb begin
        user_sel   = '0;
        simple_sel = '0;
        if (is_simple) begin
            simple_sel[simple_idx] = 1'b1;
        end else begin
            user_sel[user_idx] = 1'b1;
        end
    end

    always_comb begin
        for (int k = 0; k < tqv_periph_pkg::NUM_USER; k++) begin
            o_user_write_n[k] = user_sel[k] ? i_data_write_n : tqv_periph_pkg::ACC_NONE;
            o_user_read_n[k]  = user_sel[k] ? read_n_masked : tqv_periph_pkg::ACC_NONE;
        end
    end

    assign o_simple_write = simple_sel & {tqv_periph_pkg::NUM_SIMPLE{write_req}};

    // Simple slots answer at once with a zero-extended byte
    always_comb begin
        if (is_simple) begin
            o_sel_data  = {24'h0, i_simple_data[simple_idx]};
            o_sel_ready = 1'b1;
        end else begin
            o_sel_data  = i_user_data[user_idx];
            o_sel_ready = i_user_ready[user_idx];
        end
    end

endmodule

// File: src/periph_read_buffer.sv
// Read data buffer toward the core
// Registers the selected slot's data and holds it until the core completes the read
module periph_read_buffer (
    input  logic                  clk,
    input  logic                  rst_n,
    input  tqv_periph_pkg::acc_t  i_data_read_n,
    input  tqv_periph_pkg::acc_t  i_data_write_n,
    input  tqv_periph_pkg::word_t i_sel_data,
    input  logic                  i_sel_ready,
    input  logic                  i_read_complete,
    output tqv_periph_pkg::word_t o_data,
    output logic                  o_data_ready,
    output logic                  o_read_blocked
);

    logic                  read_req;
    logic                  capture;
    logic                  hold;
    logic                  ready_r;
    tqv_periph_pkg::word_t data_r;

    assign read_req = (i_data_read_n != tqv_periph_pkg::ACC_NONE);
    assign capture  = read_req && i_sel_ready && !hold;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hold    <= 1'b0;
            ready_r <= 1'b0;
        end else begin
            if (capture) begin
                hold <= 1'b1;
            end else if (i_read_complete) begin
                hold <= 1'b0;               // Core has taken the data
            end
            ready_r <= read_req && i_sel_ready;  // Follows data_r by construction
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            data_r <= i_sel_data;
        end
    end

    assign o_data         = data_r;
    assign o_read_blocked = ready_r;
    assign o_data_ready   = ready_r || (i_data_write_n != tqv_periph_pkg::ACC_NONE);

endmodule

// File: src/pin_out_mux.sv
// Output pin mux
// Each pin takes its own bit from whichever slot its function select names
module pin_out_mux (
    input  tqv_periph_pkg::pin_sel_t [tqv_periph_pkg::NUM_PINS-1:0]   i_pin_sel,
    input  tqv_periph_pkg::pins_t    [tqv_periph_pkg::NUM_USER-1:0]   i_user_uo,
    input  tqv_periph_pkg::pins_t    [tqv_periph_pkg::NUM_SIMPLE-1:0] i_simple_uo,
    output tqv_periph_pkg::pins_t                                     o_uo_out
);

    for (genvar i = 0; i < tqv_periph_pkg::NUM_PINS; i++) begin : g_pin
        tqv_periph_pkg::pin_sel_t sel;
        logic [4:0]               user_idx;     // Bit 5 once reached the upper bank
        logic [3:0]               simple_idx;
        logic                     pin_bit;

        assign sel        = i_pin_sel[i];
        assign user_idx   = {sel[5], sel[3:0]};
        assign simple_idx = sel[3:0];

        always_comb begin
            pin_bit = 1'b0;                     // Unimplemented slots drive low
            if (sel[4]) begin
                if (simple_idx < tqv_periph_pkg::NUM_SIMPLE) begin
                    pin_bit = i_simple_uo[simple_idx[tqv_periph_pkg::SIMPLE_IDX_W-1:0]][i];
                end
            end else if (user_idx < tqv_periph_pkg::NUM_USER) begin
                pin_bit = i_user_uo[user_idx[tqv_periph_pkg::USER_IDX_W-1:0]][i];
            end
        end

        assign o_uo_out[i] = pin_bit;
    end

endmodule

// File: src/tqv_periph_fabric.sv
// Peripheral bus fabric top level
// Joins the address decoder, read buffer, GPIO block and pin mux to the external slots
module tqv_periph_fabric (
    input  logic                                                     clk,
    input  logic                                                     rst_n,

    // Core side
    input  tqv_periph_pkg::addr_t                                    i_addr,
    input  tqv_periph_pkg::word_t                                    i_data,
    input  tqv_periph_pkg::acc_t                                     i_data_write_n,
    input  tqv_periph_pkg::acc_t                                     i_data_read_n,
    input  logic                                                     i_read_complete,
    input  tqv_periph_pkg::pins_t                                    i_ui_in,
    output tqv_periph_pkg::word_t                                    o_data,
    output logic                                                     o_data_ready,
    output tqv_periph_pkg::pins_t                                    o_uo_out,

    // Broadcast to every external slot
    output logic [5:0]                                               o_slot_addr,
    output tqv_periph_pkg::word_t                                    o_slot_data,

    // External user slots 2 and up
    output tqv_periph_pkg::acc_t  [tqv_periph_pkg::NUM_USER-1:2]     o_user_write_n,
    output tqv_periph_pkg::acc_t  [tqv_periph_pkg::NUM_USER-1:2]     o_user_read_n,
    input  tqv_periph_pkg::word_t [tqv_periph_pkg::NUM_USER-1:2]     i_user_data,
    input  logic                  [tqv_periph_pkg::NUM_USER-1:2]     i_user_ready,
    input  tqv_periph_pkg::pins_t [tqv_periph_pkg::NUM_USER-1:2]     i_user_uo,

    // Simple slots
    output logic                  [tqv_periph_pkg::NUM_SIMPLE-1:0]   o_simple_write,
    input  tqv_periph_pkg::byte_t [tqv_periph_pkg::NUM_SIMPLE-1:0]   i_simple_data,
    input  tqv_periph_pkg::pins_t [tqv_periph_pkg::NUM_SIMPLE-1:0]   i_simple_uo
);

    tqv_periph_pkg::word_t    [tqv_periph_pkg::NUM_USER-1:0] user_data;
    logic                     [tqv_periph_pkg::NUM_USER-1:0] user_ready;
    tqv_periph_pkg::pins_t    [tqv_periph_pkg::NUM_USER-1:0] user_uo;
    tqv_periph_pkg::acc_t     [tqv_periph_pkg::NUM_USER-1:0] user_write_n;
    tqv_periph_pkg::acc_t     [tqv_periph_pkg::NUM_USER-1:0] user_read_n;
    tqv_periph_pkg::pin_sel_t [tqv_periph_pkg::NUM_PINS-1:0] pin_sel;
    tqv_periph_pkg::word_t                                   sel_data;
    logic                                                    sel_ready;
    logic                                                    read_blocked;
    tqv_periph_pkg::word_t                                   gpio_rdata;
    tqv_periph_pkg::pins_t                                   gpio_out;

    // Slot 0 is reserved: reads zero, never ready, drives no pins
    assign user_data[0]  = '0;
    assign user_ready[0] = 1'b0;
    assign user_uo[0]    = '0;

    // GPIO answers every access at once
    assign user_data[tqv_periph_pkg::SLOT_GPIO]  = gpio_rdata;
    assign user_ready[tqv_periph_pkg::SLOT_GPIO] = 1'b1;
    assign user_uo[tqv_periph_pkg::SLOT_GPIO]    = gpio_out;

    assign user_data[tqv_periph_pkg::NUM_USER-1:2]  = i_user_data;
    assign user_ready[tqv_periph_pkg::NUM_USER-1:2] = i_user_ready;
    assign user_uo[tqv_periph_pkg::NUM_USER-1:2]    = i_user_uo;

    assign o_user_write_n = user_write_n[tqv_periph_pkg::NUM_USER-1:2];
    assign o_user_read_n  = user_read_n[tqv_periph_pkg::NUM_USER-1:2];
    assign o_slot_addr    = i_addr[5:0];
    assign o_slot_data    = i_data;

    periph_addr_decode decode_i (
        .i_addr         (i_addr),
        .i_data_write_n (i_data_write_n),
        .i_data_read_n  (i_data_read_n),
        .i_read_blocked (read_blocked),
        .i_user_data    (user_data),
        .i_user_ready   (user_ready),
        .i_simple_data  (i_simple_data),
        .o_user_write_n (user_write_n),
        .o_user_read_n  (user_read_n),
        .o_simple_write (o_simple_write),
        .o_sel_data     (sel_data),
        .o_sel_ready    (sel_ready)
    );

    periph_read_buffer buffer_i (
        .clk             (clk),
        .rst_n           (rst_n),
        .i_data_read_n   (i_data_read_n),
        .i_data_write_n  (i_data_write_n),
        .i_sel_data      (sel_data),
        .i_sel_ready     (sel_ready),
        .i_read_complete (i_read_complete),
        .o_data          (o_data),
        .o_data_ready    (o_data_ready),
        .o_read_blocked  (read_blocked)
    );

    gpio_regs gpio_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_slot_addr (i_addr[5:0]),
        .i_data      (i_data),
        .i_write_n   (user_write_n[tqv_periph_pkg::SLOT_GPIO]),
        .i_ui_in     (i_ui_in),
        .o_rdata     (gpio_rdata),
        .o_gpio_out  (gpio_out),
        .o_pin_sel   (pin_sel)
    );

    pin_out_mux pin_mux_i (
        .i_pin_sel   (pin_sel),
        .i_user_uo   (user_uo),
        .i_simple_uo (i_simple_uo),
        .o_uo_out    (o_uo_out)
    );

endmodule

// File: src/tqv_periph_pkg.sv
// Peripheral bus fabric shared definitions
// Slot map, GPIO register offsets and the bus vector types
package tqv_periph_pkg;

    localparam int NUM_USER   = 8;    // Full-interface slots, 64-byte windows
    localparam int NUM_SIMPLE = 4;    // Byte-access slots, 16-byte windows
    localparam int NUM_PINS   = 8;

    // Index widths for the slot arrays
    localparam int USER_IDX_W   = $clog2(NUM_USER);
    localparam int SIMPLE_IDX_W = $clog2(NUM_SIMPLE);

    localparam int SLOT_GPIO = 1;
    localparam int SLOT_UART = 2;     // Owns pins 0 and 1 out of reset

    // GPIO register map within its window
    localparam logic [5:0] GPIO_OUT_OFS  = 6'h00;
    localparam logic [5:0] GPIO_IN_OFS   = 6'h04;
    localparam logic [5:0] GPIO_SEL_BASE = 6'h20;  // Pin selects at a 4-byte stride

    typedef logic [10:0]         addr_t;
    typedef logic [31:0]         word_t;
    typedef logic [7:0]          byte_t;
    typedef logic [NUM_PINS-1:0] pins_t;

    // Access code, 11 is idle and 00/01/10 select byte, half and word
    typedef logic [1:0] acc_t;

    // Bit 4 picks the simple bank, bits 3:0 give the slot index
    typedef logic [5:0] pin_sel_t;

    localparam acc_t ACC_NONE = 2'b11;

endpackage
